// File: hdl/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath width
`define XLEN 32

// architectural integer registers x0..x31
`define NUM_ARCH_REGS 32

// ROB depth stays a power of two so tags wrap on their own
`define ROB_DEPTH 8
`define ROB_ID_W 3

`endif

// File: hdl/isa_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0] reg_data_t;
    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [4:0]       arf_id_t;
    typedef logic [31:0]      instr_t;

    // major opcodes of the base integer set
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        OP_ALU, OP_ALUI, OP_LUI, OP_AUIPC, OP_BRANCH,
        OP_JAL, OP_JALR, OP_LOAD, OP_STORE, OP_ILLEGAL
    } op_class_e;

    typedef struct packed {
        op_class_e  op_class;
        logic       rs1_valid;   // field exists in this format
        logic       rs2_valid;
        logic       rd_valid;    // low for x0 destinations too
        arf_id_t    rs1;
        arf_id_t    rs2;
        arf_id_t    rd;
        logic [2:0] funct3;
        reg_data_t  imm;         // already sign extended
        logic       is_sub;
        logic       is_sra;
        logic [1:0] ls_width;    // 0 byte, 1 half, 2 word
        logic       ld_unsigned;
    } decoded_t;

endpackage

`default_nettype wire

// File: hdl/uarch_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package uarch_pkg;
    import isa_pkg::*;

    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    typedef struct packed {
        instr_t instr;
        addr_t  pc;
        logic   br_dir_pred;    // 1 = predicted taken
        addr_t  br_target_pred;
    } ififo_entry_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        reg_data_t data;
    } wb_t;

    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        logic    mispred;
        addr_t   npc;
    } npc_wb_t;

    typedef enum logic [1:0] {ROB_EMPTY, ROB_PENDING, ROB_DONE} rob_state_e;

    typedef struct packed {
        logic    dst_valid;
        arf_id_t dst_arf_id;
        addr_t   pc;
    } rob_dispatch_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        logic      ready;
        reg_data_t data;
    } operand_t;

    typedef struct packed {
        operand_t   src1;
        operand_t   src2;
        logic       dst_valid;
        rob_id_t    instr_rob_id;
        reg_data_t  imm;
        addr_t      pc;
        op_class_e  op_class;
        logic [2:0] funct3;
        logic       is_sub;
        logic       is_sra;
        logic       br_dir_pred;
        addr_t      br_target_pred;
    } iiq_entry_t;

    typedef struct packed {
        logic       ld_st;        // 0 load, 1 store
        operand_t   base;
        operand_t   st;
        reg_data_t  imm;
        rob_id_t    instr_rob_id;
        logic [1:0] width;
        logic       ld_unsigned;
    } lsq_entry_t;

endpackage

`default_nettype wire

// File: hdl/rv_decode.sv
`default_nettype none

module rv_decode
    import isa_pkg::*;
(
    input  instr_t   instr,
    output decoded_t dec
);

    reg_data_t imm_i;
    reg_data_t imm_s;
    reg_data_t imm_b;
    reg_data_t imm_u;
    reg_data_t imm_j;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec          = '0;
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.rd       = instr[11:7];
        dec.funct3   = instr[14:12];
        dec.op_class = OP_ILLEGAL;
        case (opcode_e'(instr[6:0]))
            OPC_OP: begin
                dec.op_class  = OP_ALU;
                dec.rs1_valid = 1'b1;
                dec.rs2_valid = 1'b1;
                dec.rd_valid  = 1'b1;
                dec.is_sub    = instr[30] && (instr[14:12] == 3'b000);
                dec.is_sra    = instr[30] && (instr[14:12] == 3'b101);
            end
            OPC_OP_IMM: begin
                dec.op_class  = OP_ALUI;
                dec.rs1_valid = 1'b1;
                dec.rd_valid  = 1'b1;
                dec.imm       = imm_i;
                dec.is_sra    = instr[30] && (instr[14:12] == 3'b101); // srai only
            end
            OPC_LUI: begin
                dec.op_class = OP_LUI;
                dec.rd_valid = 1'b1;
                dec.imm      = imm_u;
            end
            OPC_AUIPC: begin
                dec.op_class = OP_AUIPC;
                dec.rd_valid = 1'b1;
                dec.imm      = imm_u;
            end
            OPC_BRANCH: begin
                dec.op_class  = OP_BRANCH;
                dec.rs1_valid = 1'b1;
                dec.rs2_valid = 1'b1;
                dec.imm       = imm_b;
            end
            OPC_JAL: begin
                dec.op_class = OP_JAL;
                dec.rd_valid = 1'b1;
                dec.imm      = imm_j;
            end
            OPC_JALR: begin
                dec.op_class  = OP_JALR;
                dec.rs1_valid = 1'b1;
                dec.rd_valid  = 1'b1;
                dec.imm       = imm_i;
            end
            OPC_LOAD: begin
                dec.op_class    = OP_LOAD;
                dec.rs1_valid   = 1'b1;
                dec.rd_valid    = 1'b1;
                dec.imm         = imm_i;
                dec.ls_width    = instr[13:12];
                dec.ld_unsigned = instr[14];   // lbu, lhu
            end
            OPC_STORE: begin
                dec.op_class  = OP_STORE;
                dec.rs1_valid = 1'b1;
                dec.rs2_valid = 1'b1;
                dec.imm       = imm_s;
                dec.ls_width  = instr[13:12];
            end
            default: dec.op_class = OP_ILLEGAL;
        endcase
        // writes to x0 are dropped, so they need no rename or retire
        dec.rd_valid = dec.rd_valid && (dec.rd != 5'd0);
    end

endmodule

`default_nettype wire

// File: hdl/rename_arf.sv
`default_nettype none

`include "core_cfg.svh"

module rename_arf
    import isa_pkg::*, uarch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  arf_id_t   rs1,
    input  arf_id_t   rs2,
    input  logic      rename_en,
    input  arf_id_t   rename_rd,
    input  rob_id_t   rename_tag,
    input  logic      retire_en,
    input  arf_id_t   retire_rd,
    input  rob_id_t   retire_tag,
    input  reg_data_t retire_data,
    input  logic      flush,
    output logic      rs1_committed,
    output logic      rs2_committed,
    output rob_id_t   rs1_tag,
    output rob_id_t   rs2_tag,
    output reg_data_t rs1_data,
    output reg_data_t rs2_data
);

    logic [`NUM_ARCH_REGS-1:0] committed_q;  // 1 = value lives in the register file
    rob_id_t                   tag_q  [`NUM_ARCH_REGS];
    reg_data_t                 regs_q [`NUM_ARCH_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            committed_q <= '1;
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                tag_q[i]  <= '0;
                regs_q[i] <= '0;
            end
        end else begin
            if (retire_en && (retire_rd != 5'd0)) begin
                regs_q[retire_rd] <= retire_data;
                // a younger rename of the same register keeps it speculative
                if (tag_q[retire_rd] == retire_tag)
                    committed_q[retire_rd] <= 1'b1;
            end
            if (flush) begin
                committed_q <= '1;
            end else if (rename_en && (rename_rd != 5'd0)) begin
                committed_q[rename_rd] <= 1'b0;  // overrides a retire to the same reg
                tag_q[rename_rd]       <= rename_tag;
            end
        end
    end

    // x0 is never renamed or written, so it reads committed zero
    assign rs1_committed = committed_q[rs1];
    assign rs2_committed = committed_q[rs2];
    assign rs1_tag       = tag_q[rs1];
    assign rs2_tag       = tag_q[rs2];
    assign rs1_data      = regs_q[rs1];
    assign rs2_data      = regs_q[rs2];

endmodule

`default_nettype wire

// File: hdl/reorder_buffer.sv
`default_nettype none

`include "core_cfg.svh"

module reorder_buffer
    import isa_pkg::*, uarch_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          alloc_valid,
    input  rob_dispatch_t alloc_data,
    output logic          alloc_ready,
    output rob_id_t       alloc_tag,
    input  rob_id_t       src1_tag,
    input  rob_id_t       src2_tag,
    output logic          src1_done,
    output reg_data_t     src1_data,
    output logic          src2_done,
    output reg_data_t     src2_data,
    input  wb_t           alu_wb,       // also completes branches
    input  wb_t           ld_wb,        // also completes stores
    input  npc_wb_t       alu_npc_wb,
    output logic          retire_en,
    output arf_id_t       retire_rd,
    output rob_id_t       retire_tag,
    output reg_data_t     retire_data,
    output logic          redirect_valid,
    output addr_t         redirect_pc
);

    typedef struct packed {
        reg_data_t data;
        logic      dst_valid;
        arf_id_t   dst;
        logic      mispred;
        addr_t     target;
    } rob_payload_t;

    rob_state_e          state_q [`ROB_DEPTH];
    rob_payload_t        pay_q   [`ROB_DEPTH];
    rob_id_t             head_q;
    rob_id_t             tail_q;
    logic [`ROB_ID_W:0]  count_q;
    logic                alloc_fire;
    logic                retire_go;

    assign retire_go      = (state_q[head_q] == ROB_DONE);
    assign retire_en      = retire_go && pay_q[head_q].dst_valid;
    assign retire_rd      = pay_q[head_q].dst;
    assign retire_tag     = head_q;
    assign retire_data    = pay_q[head_q].data;
    assign redirect_valid = retire_go && pay_q[head_q].mispred;
    assign redirect_pc    = pay_q[head_q].target;

    // no allocation while the buffer is being flushed
    assign alloc_ready = (count_q != (`ROB_ID_W+1)'(`ROB_DEPTH)) && !redirect_valid;
    assign alloc_tag   = tail_q;
    assign alloc_fire  = alloc_valid && alloc_ready;

    assign src1_done = (state_q[src1_tag] == ROB_DONE);
    assign src1_data = pay_q[src1_tag].data;
    assign src2_done = (state_q[src2_tag] == ROB_DONE);
    assign src2_data = pay_q[src2_tag].data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < `ROB_DEPTH; i++)
                state_q[i] <= ROB_EMPTY;
        end else if (redirect_valid) begin
            head_q  <= '0;   // wrong-path entries are all dropped
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < `ROB_DEPTH; i++)
                state_q[i] <= ROB_EMPTY;
        end else begin
            if (alloc_fire) begin
                state_q[tail_q] <= ROB_PENDING;
                tail_q          <= tail_q + 1'b1;
            end
            if (alu_wb.valid)
                state_q[alu_wb.rob_id] <= ROB_DONE;
            if (ld_wb.valid)
                state_q[ld_wb.rob_id] <= ROB_DONE;
            if (retire_go) begin
                state_q[head_q] <= ROB_EMPTY;  // head moves even without a destination
                head_q          <= head_q + 1'b1;
            end
            case ({alloc_fire, retire_go})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            pay_q[tail_q].dst_valid <= alloc_data.dst_valid;
            pay_q[tail_q].dst       <= alloc_data.dst_arf_id;
            pay_q[tail_q].mispred   <= 1'b0;
            pay_q[tail_q].target    <= alloc_data.pc + `XLEN'(4);  // fall-through
        end
        if (alu_wb.valid)
            pay_q[alu_wb.rob_id].data <= alu_wb.data;
        if (ld_wb.valid)
            pay_q[ld_wb.rob_id].data <= ld_wb.data;
        if (alu_npc_wb.valid) begin
            pay_q[alu_npc_wb.rob_id].mispred <= alu_npc_wb.mispred;
            pay_q[alu_npc_wb.rob_id].target  <= alu_npc_wb.npc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dispatch_stage.sv
`default_nettype none

module dispatch_stage
    import isa_pkg::*, uarch_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         ififo_valid,
    input  ififo_entry_t ififo_data,
    output logic         ififo_ready,
    output logic         iiq_valid,
    output iiq_entry_t   iiq_data,
    input  logic         iiq_ready,
    output logic         lsq_valid,
    output lsq_entry_t   lsq_data,
    input  logic         lsq_ready,
    input  logic         iiq_wakeup_valid,
    input  rob_id_t      iiq_wakeup_rob_id,
    input  wb_t          alu_wb,
    input  wb_t          ld_wb,
    input  npc_wb_t      alu_npc_wb,
    output logic         redirect_valid,
    output addr_t        redirect_pc
);

    decoded_t  dec;
    logic      is_ls, rob_ready, dispatch;
    logic      rs1_committed, rs2_committed, src1_done, src2_done;
    rob_id_t   rs1_tag, rs2_tag, alloc_tag, retire_tag;
    reg_data_t rs1_data, rs2_data, src1_data, src2_data, retire_data;
    logic      retire_en;
    arf_id_t   retire_rd;
    operand_t  op1, op2;

    // committed state first, then wakeup and writeback bypass, then ROB data
    function automatic operand_t merge_src(input logic exists, input logic committed,
                                           input rob_id_t tag, input reg_data_t arf_data,
                                           input logic rob_done, input reg_data_t rob_data);
        operand_t op;
        logic     alu_hit;
        logic     ld_hit;
        logic     wk_hit;
        alu_hit   = exists && !committed && alu_wb.valid && (alu_wb.rob_id == tag);
        ld_hit    = exists && !committed && ld_wb.valid && (ld_wb.rob_id == tag);
        wk_hit    = exists && !committed && iiq_wakeup_valid && (iiq_wakeup_rob_id == tag);
        op.valid  = exists;
        op.rob_id = tag;
        op.ready  = !exists || committed || rob_done || wk_hit || ld_hit || alu_hit;
        op.data   = alu_hit   ? alu_wb.data :
                    ld_hit    ? ld_wb.data  :
                    committed ? arf_data    : rob_data;
        return op;
    endfunction

    rv_decode u_decode (
        .instr (ififo_data.instr),
        .dec   (dec)
    );

    assign is_ls    = (dec.op_class == OP_LOAD) || (dec.op_class == OP_STORE);
    assign dispatch = ififo_valid && rob_ready && (is_ls ? lsq_ready : iiq_ready);

    rename_arf u_rename_arf (
        .clk           (clk),
        .rst_n         (rst_n),
        .rs1           (dec.rs1),
        .rs2           (dec.rs2),
        .rename_en     (dispatch && dec.rd_valid),
        .rename_rd     (dec.rd),
        .rename_tag    (alloc_tag),
        .retire_en     (retire_en),
        .retire_rd     (retire_rd),
        .retire_tag    (retire_tag),
        .retire_data   (retire_data),
        .flush         (redirect_valid),
        .rs1_committed (rs1_committed),
        .rs2_committed (rs2_committed),
        .rs1_tag       (rs1_tag),
        .rs2_tag       (rs2_tag),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data)
    );

    reorder_buffer u_rob (
        .clk            (clk),
        .rst_n          (rst_n),
        .alloc_valid    (dispatch),
        .alloc_data     ('{dst_valid: dec.rd_valid, dst_arf_id: dec.rd, pc: ififo_data.pc}),
        .alloc_ready    (rob_ready),
        .alloc_tag      (alloc_tag),
        .src1_tag       (rs1_tag),
        .src2_tag       (rs2_tag),
        .src1_done      (src1_done),
        .src1_data      (src1_data),
        .src2_done      (src2_done),
        .src2_data      (src2_data),
        .alu_wb         (alu_wb),
        .ld_wb          (ld_wb),
        .alu_npc_wb     (alu_npc_wb),
        .retire_en      (retire_en),
        .retire_rd      (retire_rd),
        .retire_tag     (retire_tag),
        .retire_data    (retire_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    assign op1 = merge_src(dec.rs1_valid, rs1_committed, rs1_tag, rs1_data, src1_done, src1_data);
    assign op2 = merge_src(dec.rs2_valid, rs2_committed, rs2_tag, rs2_data, src2_done, src2_data);

    assign ififo_ready = dispatch;
    assign iiq_valid   = dispatch && !is_ls;  // illegal opcodes go here as well
    assign lsq_valid   = dispatch && is_ls;

    assign iiq_data = '{
        src1: op1, src2: op2, dst_valid: dec.rd_valid, instr_rob_id: alloc_tag,
        imm: dec.imm, pc: ififo_data.pc, op_class: dec.op_class, funct3: dec.funct3,
        is_sub: dec.is_sub, is_sra: dec.is_sra, br_dir_pred: ififo_data.br_dir_pred,
        br_target_pred: ififo_data.br_target_pred
    };

    assign lsq_data = '{
        ld_st: (dec.op_class == OP_STORE), base: op1, st: op2, imm: dec.imm,
        instr_rob_id: alloc_tag, width: dec.ls_width, ld_unsigned: dec.ld_unsigned
    };

endmodule

`default_nettype wire

// File: bench/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;    // release away from the edge
    end

endmodule

`default_nettype wire

// File: bench/dispatch_tb.sv
`default_nettype none

`include "core_cfg.svh"

module dispatch_tb
    import isa_pkg::*, uarch_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 25;

    // wb and wakeup fields hold {valid, rob_id} and npc holds {valid, rob_id, mispred}
    typedef struct packed {
        logic       vld;
        instr_t     instr;
        op_class_e  cls;
        reg_data_t  imm;
        logic [1:0] rdy;      // {iiq, lsq}
        logic       rnd;      // non-target queue ready comes from the LFSR
        logic [3:0] alu;
        logic [3:0] ld;
        logic [3:0] wk;
        logic [4:0] npc;
        addr_t      npc_pc;
        logic [1:0] exp;      // {ififo_ready, redirect_valid}
    } step_t;

    logic         clk, rst_n;
    logic         ififo_valid, ififo_ready;
    ififo_entry_t ififo_data;
    logic         iiq_valid, iiq_ready, lsq_valid, lsq_ready;
    iiq_entry_t   iiq_data;
    lsq_entry_t   lsq_data;
    logic         iiq_wakeup_valid;
    rob_id_t      iiq_wakeup_rob_id;
    wb_t          alu_wb, ld_wb;
    npc_wb_t      alu_npc_wb;
    logic         redirect_valid;
    addr_t        redirect_pc;

    step_t        tbl [NUM_ROWS];
    logic [31:0]  lfsr_q = 32'hed63257c;
    int           errors = 0;

    // reference model of committed and speculative state
    logic         m_comm [`NUM_ARCH_REGS];
    rob_id_t      m_tag  [`NUM_ARCH_REGS];
    reg_data_t    m_arf  [`NUM_ARCH_REGS];
    logic [1:0]   r_st   [`ROB_DEPTH];   // 0 empty, 1 pending, 2 done
    reg_data_t    r_data [`ROB_DEPTH];
    logic         r_dv   [`ROB_DEPTH];
    arf_id_t      r_dst  [`ROB_DEPTH];
    logic         r_mis  [`ROB_DEPTH];
    addr_t        r_tgt  [`ROB_DEPTH];
    rob_id_t      r_head, r_tail;
    int           r_cnt;

    tb_clkgen #(.PERIOD(40), .RST_CYCLES(16)) u_clkgen (.clk(clk), .rst_n(rst_n));

    dispatch_stage dut0 (.*);

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic step_t mk(input logic vld, input instr_t ins, input op_class_e cls,
                                 input reg_data_t imm, input logic [1:0] rdy, input logic rnd,
                                 input logic [3:0] alu, input logic [3:0] ld,
                                 input logic [4:0] npc, input addr_t npc_pc,
                                 input logic [1:0] exp);
        return '{vld: vld, instr: ins, cls: cls, imm: imm, rdy: rdy, rnd: rnd, alu: alu,
                 ld: ld, wk: 4'b0, npc: npc, npc_pc: npc_pc, exp: exp};
    endfunction

    // operand is ready when absent, committed, done, woken up or written back this cycle
    function automatic operand_t model_src(input logic e, input arf_id_t rs);
        operand_t op;
        logic     c;
        rob_id_t  t;
        logic     ah, lh, wk;
        c  = m_comm[rs];
        t  = m_tag[rs];
        ah = e && !c && alu_wb.valid && (alu_wb.rob_id == t);
        lh = e && !c && ld_wb.valid && (ld_wb.rob_id == t);
        wk = e && !c && iiq_wakeup_valid && (iiq_wakeup_rob_id == t);
        op.valid  = e;
        op.rob_id = t;
        op.ready  = !e || c || (r_st[t] == 2'd2) || wk || lh || ah;
        op.data   = ah ? alu_wb.data : lh ? ld_wb.data : c ? m_arf[rs] : r_data[t];
        return op;
    endfunction

    task automatic model_edge(input logic go, input logic rdv, input logic redir,
                              input arf_id_t rd, input addr_t pc);
        logic    retire;
        rob_id_t h;
        retire = (r_st[r_head] == 2'd2);
        h      = r_head;
        if (retire && r_dv[h] && r_dst[h] != 5'd0) begin
            m_arf[r_dst[h]] = r_data[h];
            if (m_tag[r_dst[h]] == h)
                m_comm[r_dst[h]] = 1'b1;
        end
        if (redir) begin
            for (int k = 0; k < `NUM_ARCH_REGS; k++)
                m_comm[k] = 1'b1;
        end else if (go && rdv) begin
            m_comm[rd] = 1'b0;
            m_tag[rd]  = r_tail;
        end
        if (go) begin
            r_dv[r_tail]  = rdv;
            r_dst[r_tail] = rd;
            r_mis[r_tail] = 1'b0;
            r_tgt[r_tail] = pc + 32'd4;
        end
        if (alu_wb.valid) r_data[alu_wb.rob_id] = alu_wb.data;
        if (ld_wb.valid) r_data[ld_wb.rob_id] = ld_wb.data;
        if (alu_npc_wb.valid) begin
            r_mis[alu_npc_wb.rob_id] = alu_npc_wb.mispred;
            r_tgt[alu_npc_wb.rob_id] = alu_npc_wb.npc;
        end
        if (redir) begin
            for (int k = 0; k < `ROB_DEPTH; k++)
                r_st[k] = 2'd0;
            r_head = '0;
            r_tail = '0;
            r_cnt  = 0;
        end else begin
            if (go) r_st[r_tail] = 2'd1;
            if (go) r_tail = r_tail + 1'b1;
            if (alu_wb.valid) r_st[alu_wb.rob_id] = 2'd2;
            if (ld_wb.valid) r_st[ld_wb.rob_id] = 2'd2;
            if (retire) r_st[h] = 2'd0;
            if (retire) r_head = r_head + 1'b1;
            r_cnt = r_cnt + int'(go) - int'(retire);
        end
    endtask

    task automatic fail_now();
        errors++;
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s exp %b act %b", $time, name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_iiq(input iiq_entry_t exp, input iiq_entry_t act);
        if (act !== exp) begin
            $display("ERR %0t iiq_data exp %h act %h", $time, exp, act);
            fail_now();
        end
    endtask

    task automatic check_lsq(input lsq_entry_t exp, input lsq_entry_t act);
        if (act !== exp) begin
            $display("ERR %0t lsq_data exp %h act %h", $time, exp, act);
            fail_now();
        end
    endtask

    task automatic check_redirect(input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("ERR %0t redirect_pc exp %h act %h", $time, exp, act);
            fail_now();
        end
    endtask

    task automatic build_table();
        tbl[0]  = mk(1, 32'h00500093, OP_ALUI,  5, 2'b11, 0, 0, 0, 0, 0, 2'b10);     // addi x1
        tbl[1]  = mk(1, 32'h00108133, OP_ALU,   0, 2'b11, 0, 0, 0, 0, 0, 2'b10);     // add x2
        tbl[2]  = mk(1, 32'h123451b7, OP_LUI,   32'h12345000, 2'b11, 0, 4'b1000, 0, 0, 0, 2'b10);
        tbl[3]  = mk(1, 32'h0080a203, OP_LOAD,  8, 2'b11, 0, 0, 0, 0, 0, 2'b10);     // lw x4
        tbl[4]  = mk(1, 32'h0021a623, OP_STORE, 12, 2'b11, 0, 4'b1001, 0, 0, 0, 2'b10);
        tbl[4].wk = 4'b1010;    // x3 producer issues in the same cycle
        tbl[5]  = mk(1, 32'h404102b3, OP_ALU,   0, 2'b11, 0, 0, 4'b1011, 0, 0, 2'b10); // sub x5
        tbl[6]  = mk(1, 32'h00008067, OP_JALR,  0, 2'b11, 0, 4'b1010, 0, 0, 0, 2'b10);
        tbl[7]  = mk(1, 32'h00100313, OP_ALUI,  1, 2'b01, 1, 4'b1101, 4'b1100, 0, 0, 2'b00);
        tbl[8]  = mk(0, 32'h0, OP_ILLEGAL, 0, 2'b11, 0, 4'b1110, 0, 5'b11101, 32'h200, 2'b00);
        tbl[9]  = mk(1, 32'h00900393, OP_ALUI,  9, 2'b11, 0, 0, 0, 0, 0, 2'b10);     // addi x7
        tbl[10] = mk(0, 32'h0, OP_ILLEGAL, 0, 2'b11, 0, 0, 0, 0, 0, 2'b00);
        tbl[11] = mk(1, 32'h00100313, OP_ALUI,  1, 2'b11, 0, 0, 0, 0, 0, 2'b01);     // redirect
        tbl[12] = mk(1, 32'h00138433, OP_ALU,   0, 2'b11, 0, 0, 0, 0, 0, 2'b10);     // add x8
        for (int k = 13; k < 20; k++)
            tbl[k] = mk(1, 32'h00100313, OP_ALUI, 1, 2'b11, 0, 0, 0, 0, 0, 2'b10);
        tbl[20] = mk(1, 32'h00100313, OP_ALUI,  1, 2'b10, 1, 0, 0, 0, 0, 2'b00);     // ROB full
        tbl[21] = mk(1, 32'h00100313, OP_ALUI,  1, 2'b10, 1, 4'b1000, 0, 0, 0, 2'b00);
        tbl[22] = mk(1, 32'h00100313, OP_ALUI,  1, 2'b10, 0, 0, 0, 0, 0, 2'b00);
        tbl[23] = mk(1, 32'h006304b3, OP_ALU,   0, 2'b11, 0, 0, 0, 0, 0, 2'b10);     // add x9
        tbl[24] = mk(0, 32'h0, OP_ILLEGAL, 0, 2'b11, 0, 0, 0, 0, 0, 2'b00);
    endtask

    initial begin : watchdog
        #((NUM_ROWS + 16 + 10) * 40);
        $display("watchdog expired, the run hung");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

    initial begin : main
        step_t      r;
        logic       go, is_ls, e1, e2, rdv, redir;
        arf_id_t    rd;
        iiq_entry_t ei;
        lsq_entry_t el;
        addr_t      pc;
        ififo_valid       = 1'b0;
        ififo_data        = '0;
        iiq_ready         = 1'b0;
        lsq_ready         = 1'b0;
        iiq_wakeup_valid  = 1'b0;
        iiq_wakeup_rob_id = '0;
        alu_wb            = '0;
        ld_wb             = '0;
        alu_npc_wb        = '0;
        build_table();
        for (int k = 0; k < `NUM_ARCH_REGS; k++) begin
            m_comm[k] = 1'b1;
            m_tag[k]  = '0;
            m_arf[k]  = '0;
        end
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            r_st[k]   = 2'd0;
            r_data[k] = 'x;     // payload has no reset
            r_dv[k]   = 1'b0;
            r_dst[k]  = '0;
            r_mis[k]  = 1'b0;
            r_tgt[k]  = 'x;
        end
        r_head = '0;
        r_tail = '0;
        r_cnt  = 0;
        wait (rst_n === 1'b1);
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            #2;
            r     = tbl[i];
            pc    = 32'h1000 + 32'(4 * i);
            is_ls = (r.cls == OP_LOAD) || (r.cls == OP_STORE);
            ififo_valid = r.vld;
            ififo_data  = '{instr: r.instr, pc: pc, br_dir_pred: pc[2], br_target_pred: pc + 8};
            iiq_ready   = (r.rnd && is_ls) ? (take_bits(1) != 0) : r.rdy[1];
            lsq_ready   = (r.rnd && !is_ls) ? (take_bits(1) != 0) : r.rdy[0];
            iiq_wakeup_valid  = r.wk[3];
            iiq_wakeup_rob_id = r.wk[2:0];
            alu_wb      = '{valid: r.alu[3], rob_id: r.alu[2:0],
                            data: r.alu[3] ? take_bits(32) : 32'h0};
            ld_wb       = '{valid: r.ld[3], rob_id: r.ld[2:0],
                            data: r.ld[3] ? take_bits(32) : 32'h0};
            alu_npc_wb  = '{valid: r.npc[4], rob_id: r.npc[3:1], mispred: r.npc[0],
                            npc: r.npc_pc};
            #33;
            e1 = r.cls inside {OP_ALU, OP_ALUI, OP_BRANCH, OP_JALR, OP_LOAD, OP_STORE};
            e2 = r.cls inside {OP_ALU, OP_BRANCH, OP_STORE};
            rd = r.instr[11:7];
            rdv = !(r.cls inside {OP_BRANCH, OP_STORE, OP_ILLEGAL}) && (rd != 5'd0);
            redir = (r_st[r_head] == 2'd2) && r_mis[r_head];
            go = r.vld && (r_cnt < `ROB_DEPTH) && !redir && (is_ls ? lsq_ready : iiq_ready);
            if (go !== r.exp[1] || redir !== r.exp[0]) begin
                $display("model and table disagree on row %0d", i);
                fail_now();
            end
            check_flag("ififo_ready", r.exp[1], ififo_ready);
            check_flag("iiq_valid", go && !is_ls, iiq_valid);
            check_flag("lsq_valid", go && is_ls, lsq_valid);
            check_flag("redirect_valid", r.exp[0], redirect_valid);
            if (r.exp[0])
                check_redirect(r_tgt[r_head], redirect_pc);
            if (go && !is_ls) begin
                ei = '{src1: model_src(e1, r.instr[19:15]), src2: model_src(e2, r.instr[24:20]),
                       dst_valid: rdv, instr_rob_id: r_tail, imm: r.imm, pc: pc,
                       op_class: r.cls, funct3: r.instr[14:12],
                       is_sub: (r.cls == OP_ALU) && r.instr[30] && (r.instr[14:12] == 3'd0),
                       is_sra: (r.cls inside {OP_ALU, OP_ALUI}) && r.instr[30]
                               && (r.instr[14:12] == 3'd5),
                       br_dir_pred: pc[2], br_target_pred: pc + 8};
                check_iiq(ei, iiq_data);
            end
            if (go && is_ls) begin
                el = '{ld_st: (r.cls == OP_STORE), base: model_src(e1, r.instr[19:15]),
                       st: model_src(e2, r.instr[24:20]), imm: r.imm, instr_rob_id: r_tail,
                       width: r.instr[13:12],
                       ld_unsigned: (r.cls == OP_LOAD) && r.instr[14]};
                check_lsq(el, lsq_data);
            end
            model_edge(go, rdv, redir, rd, pc);
        end
        if (errors == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "errors found");
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/uarch_pkg.sv
hdl/rv_decode.sv
hdl/rename_arf.sv
hdl/reorder_buffer.sv
hdl/dispatch_stage.sv
bench/tb_clkgen.sv
bench/dispatch_tb.sv
